//--- common/kbd_pkg.sv
package kbd_pkg;

    // ******************************
    // ps2 frame
    // ******************************

    typedef logic [7:0] scan_code_t;

    // payload of one checked 11-bit frame
    typedef struct packed {
        scan_code_t data;
    } ps2_frame_t;

    // prefix of a break sequence
    localparam scan_code_t BREAK_CODE = 8'hF0;

    // ******************************
    // key events
    // ******************************

    typedef struct packed {
        scan_code_t code;    // last make code seen
        logic       pressed; // key currently held
        logic [7:0] count;   // new key-downs, wraps
    } key_event_t;

    // ******************************
    // state machines
    // ******************************

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

    typedef enum logic {
        WAIT_CODE,
        WAIT_BREAK
    } kbd_state_t;

endpackage

//--- common/disp_pkg.sv
package disp_pkg;

    // eight digits on the board
    localparam int NUM_DIGITS = 8;

    typedef logic [3:0] nibble_t;

    // bit 7 dp, bits 6..0 segments g..a, all active low
    typedef logic [7:0] seg_t;

    // dark digit
    localparam seg_t SEG_OFF = 8'hFF;

    // pattern for "0"
    localparam seg_t SEG_ZERO = 8'hC0;

    // digit 0 in the low nibble
    typedef nibble_t [NUM_DIGITS-1:0] digit_bank_t;

    typedef seg_t [NUM_DIGITS-1:0] seg_bank_t;

endpackage

//--- ps2_rx/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::ps2_frame_t frame,
    output logic                frame_valid
);
    import kbd_pkg::*;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] data_sync;
    logic                   clk_s;
    logic                   data_s;
    logic                   clk_prev;
    logic                   clk_fall;

    rx_state_t  state;
    logic [2:0] bit_cnt;
    scan_code_t shift;
    logic       start_bit;
    logic       parity_bit;
    logic       frame_ok;

    // ******************************
    // synchronizers, edge detect
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= '1; // lines idle high
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_s;
        end
    end

    assign clk_s    = clk_sync[SYNC_STAGES-1];
    assign data_s   = data_sync[SYNC_STAGES-1];
    assign clk_fall = clk_prev & ~clk_s;

    // start low, odd parity over data+parity, stop high
    assign frame_ok = ~start_bit & (^{shift, parity_bit}) & data_s;

    // ******************************
    // frame FSM
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    IDLE: begin
                        state   <= DATA; // any falling edge here is the start bit
                        bit_cnt <= '0;
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= PARITY;
                    end
                    PARITY: state <= STOP;
                    STOP: begin
                        frame_valid <= frame_ok; // bad frames just vanish
                        state       <= IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            case (state)
                IDLE:   start_bit  <= data_s;
                DATA:   shift      <= {data_s, shift[7:1]}; // lsb first
                PARITY: parity_bit <= data_s;
                STOP: begin
                    if (frame_ok)
                        frame.data <= shift;
                end
            endcase
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_valid |=> !frame_valid);

    a_reset_idle: assert property (@(posedge clk)
        reset |=> state == IDLE);

endmodule

//--- ps2_rx/kbd_ctrl.sv
`timescale 1ns/1ps

module kbd_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_valid,
    input  kbd_pkg::ps2_frame_t frame,
    output kbd_pkg::key_event_t key_event
);
    import kbd_pkg::*;

    kbd_state_t state;
    scan_code_t held_code;
    logic       pressed;
    logic [7:0] count;
    logic       is_break;

    assign is_break = (frame.data == BREAK_CODE);

    // ******************************
    // make / break tracking
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= WAIT_CODE;
            pressed <= 1'b0;
            count   <= '0;
        end else if (frame_valid) begin
            case (state)
                WAIT_CODE: begin
                    if (is_break) begin
                        state <= WAIT_BREAK;
                    end else begin
                        pressed <= 1'b1;
                        if (!pressed)
                            count <= count + 8'd1; // typematic repeats not counted
                    end
                end
                WAIT_BREAK: begin
                    pressed <= 1'b0; // byte after F0 ends the press
                    state   <= WAIT_CODE;
                end
            endcase
        end
    end

    // code survives the release
    always_ff @(posedge clk) begin
        if (frame_valid && state == WAIT_CODE && !is_break)
            held_code <= frame.data;
    end

    assign key_event.code    = held_code;
    assign key_event.pressed = pressed;
    assign key_event.count   = count;

    a_count_on_frame: assert property (@(posedge clk) disable iff (reset)
        !$stable(count) |-> $past(frame_valid) || $past(reset));

endmodule

//--- hdl/key_digits.sv
`timescale 1ns/1ps

module key_digits (
    input  kbd_pkg::key_event_t                key_event,
    output disp_pkg::digit_bank_t              digits,
    output logic [disp_pkg::NUM_DIGITS-1:0]    blank
);
    import kbd_pkg::*;
    import disp_pkg::*;

    // digits 2 and 5 never lit
    localparam logic [NUM_DIGITS-1:0] ALWAYS_DARK = 8'b0010_0100;
    // key and ascii digits, dark while nothing held
    localparam logic [NUM_DIGITS-1:0] KEY_DIGITS  = 8'b0001_1011;

    logic [7:0] ascii;

    // ******************************
    // scan code set 2 to ascii
    // ******************************

    always_comb begin
        case (key_event.code)
            8'h1C: ascii = 8'h41; // A
            8'h32: ascii = 8'h42;
            8'h21: ascii = 8'h43;
            8'h23: ascii = 8'h44;
            8'h24: ascii = 8'h45;
            8'h2B: ascii = 8'h46;
            8'h34: ascii = 8'h47;
            8'h33: ascii = 8'h48;
            8'h43: ascii = 8'h49;
            8'h3B: ascii = 8'h4A;
            8'h42: ascii = 8'h4B;
            8'h4B: ascii = 8'h4C;
            8'h3A: ascii = 8'h4D;
            8'h31: ascii = 8'h4E;
            8'h44: ascii = 8'h4F;
            8'h4D: ascii = 8'h50;
            8'h15: ascii = 8'h51;
            8'h2D: ascii = 8'h52;
            8'h1B: ascii = 8'h53;
            8'h2C: ascii = 8'h54;
            8'h3C: ascii = 8'h55;
            8'h2A: ascii = 8'h56;
            8'h1D: ascii = 8'h57;
            8'h22: ascii = 8'h58;
            8'h35: ascii = 8'h59;
            8'h1A: ascii = 8'h5A; // Z
            8'h45: ascii = 8'h30; // 0
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39; // 9
            8'h29: ascii = 8'h20; // space
            8'h5A: ascii = 8'h0D; // enter
            default: ascii = 8'h00;
        endcase
    end

    // ******************************
    // digit placement
    // ******************************

    always_comb begin
        digits[0] = key_event.code[3:0];
        digits[1] = key_event.code[7:4];
        digits[2] = 4'h0; // blanked
        digits[3] = ascii[3:0];
        digits[4] = ascii[7:4];
        digits[5] = 4'h0; // blanked
        digits[6] = key_event.count[3:0];
        digits[7] = key_event.count[7:4];
    end

    assign blank = ALWAYS_DARK | (key_event.pressed ? '0 : KEY_DIGITS);

endmodule

//--- hdl/hex7seg.sv
`timescale 1ns/1ps

module hex7seg (
    input  disp_pkg::nibble_t digit,
    output disp_pkg::seg_t    seg
);

    // active low, dp held off in bit 7
    always_comb begin
        case (digit)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83; // lower case b
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1; // lower case d
            4'hE: seg = 8'h86;
            4'hF: seg = 8'h8E;
        endcase
    end

endmodule

//--- hdl/seg_latch.sv
`timescale 1ns/1ps

module seg_latch (
    input  logic                             clk,
    input  logic                             reset,
    input  disp_pkg::seg_bank_t              raw,
    input  logic [disp_pkg::NUM_DIGITS-1:0]  blank,
    output disp_pkg::seg_bank_t              seg
);
    import disp_pkg::*;

    // count reads 00, everything else dark
    localparam seg_bank_t RESET_BANK = {SEG_ZERO, SEG_ZERO, {(NUM_DIGITS-2){SEG_OFF}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            seg <= RESET_BANK;
        end else begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                seg[i] <= blank[i] ? SEG_OFF : raw[i];
            end
        end
    end

    // ******************************
    // blanking check
    // ******************************

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_chk
        a_blank_dark: assert property (@(posedge clk) disable iff (reset)
            blank[i] |=> seg[i] == SEG_OFF);
    end

endmodule

//--- hdl/kbd_display_top.sv
`timescale 1ns/1ps

module kbd_display_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output disp_pkg::seg_bank_t seg,
    output logic                is_press
);
    import kbd_pkg::*;
    import disp_pkg::*;

    ps2_frame_t             frame;
    logic                   frame_valid;
    key_event_t             key_event;
    digit_bank_t            digits;
    logic [NUM_DIGITS-1:0]  blank;
    seg_bank_t              raw_seg;

    ps2_rx #(
        .SYNC_STAGES ( SYNC_STAGES )
    ) u_ps2_rx (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .ps2_clk     ( ps2_clk     ),
        .ps2_data    ( ps2_data    ),
        .frame       ( frame       ),
        .frame_valid ( frame_valid )
    );

    kbd_ctrl u_kbd_ctrl (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .frame_valid ( frame_valid ),
        .frame       ( frame       ),
        .key_event   ( key_event   )
    );

    key_digits u_key_digits (
        .key_event   ( key_event   ),
        .digits      ( digits      ),
        .blank       ( blank       )
    );

    // one decoder per digit
    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_hex
        hex7seg u_hex7seg (
            .digit ( digits[i]  ),
            .seg   ( raw_seg[i] )
        );
    end

    seg_latch u_seg_latch (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .raw         ( raw_seg     ),
        .blank       ( blank       ),
        .seg         ( seg         )
    );

    assign is_press = key_event.pressed;

endmodule

//--- tb/tb_kbd_display.sv
`timescale 1ns/1ps

module tb_kbd_display;
    import disp_pkg::*;

    localparam int HALF_PERIOD = 40; // system clocks per ps2 half period
    localparam int TIMEOUT     = 500;
    localparam int STEADY      = 16;

    logic        clk;
    logic        reset;
    logic        ps2_clk;
    logic        ps2_data;
    seg_bank_t   seg;
    logic        is_press;

    int          errors;
    int          checks;
    logic [7:0]  exp_count;
    logic [7:0]  last_code;

    // active low with g..a in bits 6..0
    seg_t hex_table [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                             8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

    // set 2 make codes for A..Z and 0..9
    logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
                                      8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                      8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C,
                                      8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    logic [7:0] number_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                      8'h3D, 8'h3E, 8'h46};

    kbd_display_top #(
        .SYNC_STAGES ( 2        )
    ) u_kbd_display_top (
        .clk         ( clk      ),
        .reset       ( reset    ),
        .ps2_clk     ( ps2_clk  ),
        .ps2_data    ( ps2_data ),
        .seg         ( seg      ),
        .is_press    ( is_press )
    );

    always #4 clk = ~clk;

    // ******************************
    // reference model
    // ******************************

    function automatic logic [7:0] ascii_ref(input logic [7:0] code);
        logic [7:0] result;
        result = 8'h00;
        for (int i = 0; i < 26; i++)
            if (letter_codes[i] == code) result = 8'h41 + 8'(i);
        for (int i = 0; i < 10; i++)
            if (number_codes[i] == code) result = 8'h30 + 8'(i);
        if (code == 8'h29) result = 8'h20; // space
        if (code == 8'h5A) result = 8'h0D; // enter
        return result;
    endfunction

    function automatic seg_bank_t expected_bank(input logic [7:0] code, input logic pressed,
                                                input logic [7:0] count);
        seg_bank_t  bank;
        logic [7:0] asc;
        asc     = ascii_ref(code);
        bank    = '1;
        bank[6] = hex_table[count[3:0]];
        bank[7] = hex_table[count[7:4]];
        if (pressed) begin
            bank[0] = hex_table[code[3:0]];
            bank[1] = hex_table[code[7:4]];
            bank[3] = hex_table[asc[3:0]];
            bank[4] = hex_table[asc[7:4]];
        end
        return bank;
    endfunction

    // ******************************
    // drivers and checkers
    // ******************************

    task automatic wait_clocks(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input logic [7:0] data, input bit bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = ~^data ^ bad_parity; // odd parity unless corrupted
        bits   = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            wait_clocks(HALF_PERIOD);
            ps2_clk = 1'b0; // receiver samples here
            wait_clocks(HALF_PERIOD);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        wait_clocks(2 * HALF_PERIOD);
    endtask

    task automatic compare_outputs(input seg_bank_t exp, input logic pressed, input string what);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            checks++;
            assert (seg[i] === exp[i]) else begin
                errors++;
                $display("Fail seg[%0d] got %h expected %h (%s)", i, seg[i], exp[i], what);
            end
        end
        checks++;
        assert (is_press === pressed) else begin
            errors++;
            $display("Fail is_press got %h expected %h (%s)", is_press, pressed, what);
        end
    endtask

    task automatic check_display(input logic [7:0] code, input logic pressed, input string what);
        seg_bank_t exp;
        int        n;
        exp = expected_bank(code, pressed, exp_count);
        n   = 0;
        while ((seg !== exp || is_press !== pressed) && n < TIMEOUT) begin
            wait_clocks(1);
            n++;
        end
        assert (n < TIMEOUT) else begin
            errors++;
            $display("%s: display did not reach the expected value in %0d cycles", what, TIMEOUT);
        end
        compare_outputs(exp, pressed, what);
    endtask

    // display must hold still over a short window
    task automatic check_steady(input logic [7:0] code, input logic pressed, input string what);
        seg_bank_t exp;
        int        n;
        exp = expected_bank(code, pressed, exp_count);
        n   = 0;
        while (seg === exp && is_press === pressed && n < STEADY) begin
            wait_clocks(1);
            n++;
        end
        compare_outputs(exp, pressed, what);
    endtask

    // ******************************
    // tests
    // ******************************

    task automatic test_reset();
        exp_count = 8'h00;
        check_display(8'h00, 1'b0, "reset");
    endtask

    task automatic test_press();
        send_byte(8'h1C, 1'b0);
        exp_count = exp_count + 8'd1;
        last_code = 8'h1C;
        check_display(8'h1C, 1'b1, "press");
    endtask

    task automatic test_release();
        send_byte(8'hF0, 1'b0);
        check_steady(8'h1C, 1'b1, "break prefix");
        send_byte(8'h1C, 1'b0);
        check_display(8'h1C, 1'b0, "release");
    endtask

    task automatic test_repeat_and_new();
        int         idx;
        logic [7:0] code;
        send_byte(8'h1C, 1'b0);
        exp_count = exp_count + 8'd1;
        check_display(8'h1C, 1'b1, "second press");
        send_byte(8'h1C, 1'b0); // typematic repeat
        check_steady(8'h1C, 1'b1, "repeat");
        send_byte(8'hF0, 1'b0);
        send_byte(8'h1C, 1'b0);
        check_display(8'h1C, 1'b0, "release before letter");
        idx  = int'($urandom % 26);
        code = letter_codes[idx];
        send_byte(code, 1'b0);
        exp_count = exp_count + 8'd1;
        check_display(code, 1'b1, "random letter");
        send_byte(8'hF0, 1'b0);
        send_byte(code, 1'b0);
        last_code = code;
        check_display(code, 1'b0, "random letter release");
    endtask

    task automatic test_bad_frame();
        send_byte(8'h2D, 1'b1);
        check_steady(last_code, 1'b0, "bad parity");
        send_byte(8'h76, 1'b0); // escape has no ascii
        exp_count = exp_count + 8'd1;
        last_code = 8'h76;
        check_display(8'h76, 1'b1, "unmapped code");
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        errors    = 0;
        checks    = 0;
        exp_count = 8'h00;
        last_code = 8'h00;
        void'($urandom(31));
        wait_clocks(10);
        reset = 1'b0;

        test_reset();
        test_press();
        test_release();
        test_repeat_and_new();
        test_bad_frame();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- vlog.f
common/kbd_pkg.sv
common/disp_pkg.sv
ps2_rx/ps2_rx.sv
ps2_rx/kbd_ctrl.sv
hdl/key_digits.sv
hdl/hex7seg.sv
hdl/seg_latch.sv
hdl/kbd_display_top.sv
tb/tb_kbd_display.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_kbd_display
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG); cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
